// ==== common/vp_settings.svh ====
// Sparse weight encoder sizes
`ifndef VP_SETTINGS_SVH
`define VP_SETTINGS_SVH

// weight table entries
`define VP_W_LEN      32
// input activation channels
`define VP_IA_CHANNEL 8
// weight and activation word
`define VP_DATA_W     16
// entry address, lanes times bits per lane
`define VP_ADDR_LANES 3
`define VP_ADDR_W     7
// activation channel position
`define VP_POS_W      9
// slots in each output bank
`define VP_BANK_DEPTH 3
// entries looked at per cycle
`define VP_WINDOW     3

`endif

// ==== common/vp_pkg.sv ====
// Sparse weight encoder types
`include "vp_settings.svh"

package vp_pkg;

    // table index, room for one window past the end
    localparam int IDX_W  = $clog2(`VP_W_LEN + `VP_WINDOW);
    // select widths into the entry and channel arrays
    localparam int ENT_W  = $clog2(`VP_W_LEN);
    localparam int CH_W   = $clog2(`VP_IA_CHANNEL);
    localparam int SLOT_W = $clog2(`VP_BANK_DEPTH);

    // signed weight or activation
    typedef logic signed [`VP_DATA_W-1:0] data_t;

    // three-lane packed address
    typedef logic [`VP_ADDR_LANES-1:0][`VP_ADDR_W-1:0] addr_t;

    typedef logic [`VP_POS_W-1:0] pos_t;
    typedef logic [IDX_W-1:0]     idx_t;
    typedef logic [SLOT_W-1:0]    slot_t;

    // right bank fills first in every run
    typedef enum logic {
        BANK_RIGHT = 1'b0,
        BANK_LEFT  = 1'b1
    } bank_e;

    // one gathered operand triple
    typedef struct packed {
        addr_t addr;
        data_t w_data;
        data_t ia_data;
    } item_t;

endpackage

// ==== common/vp_item_if.sv ====
// Gathered item bus
`timescale 1ns/1ps

interface vp_item_if;

    // one cycle per gathered item
    logic           wr;
    // end of run, slot holds the fill count
    logic           flush;
    // target slot, or count on flush
    vp_pkg::slot_t  slot;
    vp_pkg::bank_e  bank;
    vp_pkg::item_t  item;

    // gather side
    modport src (
        output wr,
        output flush,
        output slot,
        output bank,
        output item
    );

    // bank pair side, always accepts
    modport dst (
        input wr,
        input flush,
        input slot,
        input bank,
        input item
    );

endinterface

// ==== rtl/vp_scan_ctrl.sv ====
// Window scanner and run control
`timescale 1ns/1ps
`include "vp_settings.svh"

module vp_scan_ctrl (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_start,
    input  logic          i_valid_buf [0:`VP_W_LEN-1],
    input  vp_pkg::idx_t  i_w_len,
    output logic          o_pick,
    output vp_pkg::idx_t  o_pick_idx,
    output vp_pkg::slot_t o_slot,
    output vp_pkg::bank_e o_bank,
    output logic          o_tail
);

    localparam vp_pkg::slot_t SLOT_LAST = vp_pkg::slot_t'(`VP_BANK_DEPTH - 1);

    logic                  busy_q;
    vp_pkg::idx_t          idx_q;
    vp_pkg::slot_t         slot_q;
    vp_pkg::bank_e         bank_q;

    // length clamped to the table
    vp_pkg::idx_t          len_eff;
    logic [`VP_WINDOW-1:0] win_v;
    vp_pkg::idx_t          pick_off;
    vp_pkg::idx_t          step;
    logic                  at_end;
    logic                  any_v;

    always_comb begin
        if (i_w_len > vp_pkg::idx_t'(`VP_W_LEN)) begin
            len_eff = vp_pkg::idx_t'(`VP_W_LEN);
        end else begin
            len_eff = i_w_len;
        end
    end

    // entries at or past the length read as invalid
    always_comb begin : win_mask
        vp_pkg::idx_t ent;
        for (int k = 0; k < `VP_WINDOW; k++) begin
            ent = idx_q + vp_pkg::idx_t'(k);
            win_v[k] = (ent < len_eff) && i_valid_buf[ent[vp_pkg::ENT_W-1:0]];
        end
    end

    // lowest valid offset wins
    always_comb begin
        pick_off = '0;
        for (int k = `VP_WINDOW - 1; k >= 0; k--) begin
            if (win_v[k]) begin
                pick_off = vp_pkg::idx_t'(k);
            end
        end
    end

    assign any_v  = |win_v;
    assign at_end = idx_q >= len_eff;
    // step past the pick or over an empty window
    assign step   = any_v ? pick_off + vp_pkg::idx_t'(1) : vp_pkg::idx_t'(`VP_WINDOW);

    assign o_pick     = busy_q && any_v;
    assign o_tail     = busy_q && at_end;
    assign o_pick_idx = idx_q + pick_off;
    assign o_slot     = slot_q;
    assign o_bank     = bank_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
            slot_q <= '0;
            bank_q <= vp_pkg::BANK_RIGHT;
        end else if (!busy_q) begin
            // start only honored from idle
            if (i_start) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
                slot_q <= '0;
                bank_q <= vp_pkg::BANK_RIGHT;
            end
        end else if (at_end) begin
            // tail cycle returns to idle on the right bank
            busy_q <= 1'b0;
            slot_q <= '0;
            bank_q <= vp_pkg::BANK_RIGHT;
        end else begin
            idx_q <= idx_q + step;
            if (any_v) begin
                if (slot_q == SLOT_LAST) begin
                    slot_q <= '0;
                    bank_q <= (bank_q == vp_pkg::BANK_RIGHT) ? vp_pkg::BANK_LEFT
                                                             : vp_pkg::BANK_RIGHT;
                end else begin
                    slot_q <= slot_q + vp_pkg::slot_t'(1);
                end
            end
        end
    end

    // window mask alone keeps picks out of the tail cycle
    a_tail_quiet: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_tail |-> !o_pick
    );

endmodule

// ==== rtl/vp_operand_gather.sv ====
// Operand gather stage
`timescale 1ns/1ps
`include "vp_settings.svh"

module vp_operand_gather (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_pick,
    input  vp_pkg::idx_t  i_pick_idx,
    input  vp_pkg::slot_t i_slot,
    input  vp_pkg::bank_e i_bank,
    input  logic          i_tail,
    input  vp_pkg::addr_t i_addr_buf [0:`VP_W_LEN-1],
    input  vp_pkg::pos_t  i_pos_buf  [0:`VP_W_LEN-1],
    input  vp_pkg::data_t i_w_data   [0:`VP_W_LEN-1],
    input  vp_pkg::data_t i_ia_data  [0:`VP_IA_CHANNEL-1],
    vp_item_if.src        item_out
);

    logic [vp_pkg::ENT_W-1:0] ent;
    vp_pkg::pos_t             pos;
    vp_pkg::item_t            sel_item;

    // picked index is always inside the table
    assign ent = i_pick_idx[vp_pkg::ENT_W-1:0];
    assign pos = i_pos_buf[ent];

    always_comb begin
        sel_item.addr    = i_addr_buf[ent];
        sel_item.w_data  = i_w_data[ent];
        // activation chosen by the entry's channel position
        sel_item.ia_data = i_ia_data[pos[vp_pkg::CH_W-1:0]];
    end

    // strobes and tags, one cycle behind the scanner
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            item_out.wr    <= 1'b0;
            item_out.flush <= 1'b0;
            item_out.slot  <= '0;
            item_out.bank  <= vp_pkg::BANK_RIGHT;
        end else begin
            item_out.wr    <= i_pick;
            item_out.flush <= i_tail;
            item_out.slot  <= i_slot;
            item_out.bank  <= i_bank;
        end
    end

    // payload only moves on a pick
    always_ff @(posedge i_clk) begin
        if (i_pick) begin
            item_out.item <= sel_item;
        end
    end

    // table positions must point at a real channel
    a_pos_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_pick |-> (pos < vp_pkg::pos_t'(`VP_IA_CHANNEL))
    );

endmodule

// ==== rtl/vp_bank_pair.sv ====
// Ping-pong output banks
`timescale 1ns/1ps
`include "vp_settings.svh"

module vp_bank_pair (
    input  logic          i_clk,
    input  logic          i_rst_n,
    vp_item_if.dst        item_in,
    output logic          o_right_ready,
    output logic          o_left_ready,
    output logic          o_finish,
    output vp_pkg::item_t o_right_bank [0:`VP_BANK_DEPTH-1],
    output vp_pkg::item_t o_left_bank  [0:`VP_BANK_DEPTH-1]
);

    localparam vp_pkg::slot_t SLOT_LAST = vp_pkg::slot_t'(`VP_BANK_DEPTH - 1);

    vp_pkg::item_t right_q [0:`VP_BANK_DEPTH-1];
    vp_pkg::item_t left_q  [0:`VP_BANK_DEPTH-1];
    logic          right_ready_q;
    logic          left_ready_q;
    logic          finish_q;

    logic          to_right;
    logic          tail_fill;
    // bank complete, either by its last slot or by a tail
    logic          publish;

    assign to_right  = item_in.bank == vp_pkg::BANK_RIGHT;
    assign tail_fill = item_in.flush && (item_in.slot != '0);
    assign publish   = (item_in.wr && item_in.slot == SLOT_LAST) || tail_fill;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < `VP_BANK_DEPTH; s++) begin
                right_q[s] <= '0;
                left_q[s]  <= '0;
            end
            right_ready_q <= 1'b0;
            left_ready_q  <= 1'b0;
            finish_q      <= 1'b0;
        end else begin
            // ready lands together with the last write
            right_ready_q <= publish && to_right;
            left_ready_q  <= publish && !to_right;
            finish_q      <= item_in.flush;
            if (item_in.wr) begin
                if (to_right) begin
                    right_q[item_in.slot] <= item_in.item;
                end else begin
                    left_q[item_in.slot] <= item_in.item;
                end
            end else if (tail_fill) begin
                // clear operands of unfilled slots, addresses stay
                for (int s = 0; s < `VP_BANK_DEPTH; s++) begin
                    if (vp_pkg::slot_t'(s) >= item_in.slot) begin
                        if (to_right) begin
                            right_q[s].w_data  <= '0;
                            right_q[s].ia_data <= '0;
                        end else begin
                            left_q[s].w_data  <= '0;
                            left_q[s].ia_data <= '0;
                        end
                    end
                end
            end
        end
    end

    assign o_right_ready = right_ready_q;
    assign o_left_ready  = left_ready_q;
    assign o_finish      = finish_q;
    assign o_right_bank  = right_q;
    assign o_left_bank   = left_q;

    // one bank per pulse, and never two pulses back to back
    a_ready_excl: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_right_ready || o_left_ready) |->
            (o_right_ready != o_left_ready) ##1 !(o_right_ready || o_left_ready)
    );

endmodule

// ==== rtl/vp_encoder.sv ====
// Sparse weight encoder top
`timescale 1ns/1ps
`include "vp_settings.svh"

module vp_encoder (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_start,
    input  vp_pkg::addr_t i_addr_buf  [0:`VP_W_LEN-1],
    input  logic          i_valid_buf [0:`VP_W_LEN-1],
    input  vp_pkg::pos_t  i_pos_buf   [0:`VP_W_LEN-1],
    input  vp_pkg::data_t i_w_data    [0:`VP_W_LEN-1],
    input  vp_pkg::data_t i_ia_data   [0:`VP_IA_CHANNEL-1],
    input  vp_pkg::idx_t  i_w_len,
    output logic          o_right_ready,
    output logic          o_left_ready,
    output vp_pkg::addr_t o_addr_right_buffer    [0:`VP_BANK_DEPTH-1],
    output vp_pkg::data_t o_w_data_right_buffer  [0:`VP_BANK_DEPTH-1],
    output vp_pkg::data_t o_ia_data_right_buffer [0:`VP_BANK_DEPTH-1],
    output vp_pkg::addr_t o_addr_left_buffer     [0:`VP_BANK_DEPTH-1],
    output vp_pkg::data_t o_w_data_left_buffer   [0:`VP_BANK_DEPTH-1],
    output vp_pkg::data_t o_ia_data_left_buffer  [0:`VP_BANK_DEPTH-1],
    output logic          o_finish
);

    // scanner to gather
    logic          pick;
    vp_pkg::idx_t  pick_idx;
    vp_pkg::slot_t slot;
    vp_pkg::bank_e bank;
    logic          tail;

    vp_pkg::item_t right_bank [0:`VP_BANK_DEPTH-1];
    vp_pkg::item_t left_bank  [0:`VP_BANK_DEPTH-1];

    // gather to banks
    vp_item_if item_bus ();

    vp_scan_ctrl scan_ctrl_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_valid_buf (i_valid_buf),
        .i_w_len     (i_w_len),
        .o_pick      (pick),
        .o_pick_idx  (pick_idx),
        .o_slot      (slot),
        .o_bank      (bank),
        .o_tail      (tail)
    );

    vp_operand_gather operand_gather_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pick     (pick),
        .i_pick_idx (pick_idx),
        .i_slot     (slot),
        .i_bank     (bank),
        .i_tail     (tail),
        .i_addr_buf (i_addr_buf),
        .i_pos_buf  (i_pos_buf),
        .i_w_data   (i_w_data),
        .i_ia_data  (i_ia_data),
        .item_out   (item_bus.src)
    );

    vp_bank_pair bank_pair_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .item_in       (item_bus.dst),
        .o_right_ready (o_right_ready),
        .o_left_ready  (o_left_ready),
        .o_finish      (o_finish),
        .o_right_bank  (right_bank),
        .o_left_bank   (left_bank)
    );

    // split items into the per-field output arrays
    for (genvar s = 0; s < `VP_BANK_DEPTH; s++) begin : g_split
        assign o_addr_right_buffer[s]    = right_bank[s].addr;
        assign o_w_data_right_buffer[s]  = right_bank[s].w_data;
        assign o_ia_data_right_buffer[s] = right_bank[s].ia_data;
        assign o_addr_left_buffer[s]     = left_bank[s].addr;
        assign o_w_data_left_buffer[s]   = left_bank[s].w_data;
        assign o_ia_data_left_buffer[s]  = left_bank[s].ia_data;
    end

endmodule

// ==== bench/tb_vp_encoder.sv ====
// Sparse encoder testbench
`timescale 1ns/1ps
`include "vp_settings.svh"

module tb_vp_encoder;

    localparam int DEPTH       = `VP_BANK_DEPTH;
    localparam int FIN_TIMEOUT = 200;
    localparam int FILL_DENSE  = 0;
    localparam int FILL_SPARSE = 1;
    localparam int FILL_EMPTY  = 2;

    logic          i_clk;
    logic          i_rst_n;
    logic          i_start;
    vp_pkg::addr_t i_addr_buf  [0:`VP_W_LEN-1];
    logic          i_valid_buf [0:`VP_W_LEN-1];
    vp_pkg::pos_t  i_pos_buf   [0:`VP_W_LEN-1];
    vp_pkg::data_t i_w_data    [0:`VP_W_LEN-1];
    vp_pkg::data_t i_ia_data   [0:`VP_IA_CHANNEL-1];
    vp_pkg::idx_t  i_w_len;
    logic          o_right_ready;
    logic          o_left_ready;
    logic          o_finish;
    vp_pkg::addr_t o_addr_right_buffer    [0:DEPTH-1];
    vp_pkg::data_t o_w_data_right_buffer  [0:DEPTH-1];
    vp_pkg::data_t o_ia_data_right_buffer [0:DEPTH-1];
    vp_pkg::addr_t o_addr_left_buffer     [0:DEPTH-1];
    vp_pkg::data_t o_w_data_left_buffer   [0:DEPTH-1];
    vp_pkg::data_t o_ia_data_left_buffer  [0:DEPTH-1];

    // model copy of the table
    vp_pkg::addr_t tbl_addr  [0:`VP_W_LEN-1];
    logic          tbl_valid [0:`VP_W_LEN-1];
    vp_pkg::pos_t  tbl_pos   [0:`VP_W_LEN-1];
    vp_pkg::data_t tbl_w     [0:`VP_W_LEN-1];
    vp_pkg::data_t tbl_ia    [0:`VP_IA_CHANNEL-1];

    // expected groups of three items over all runs
    vp_pkg::item_t exp_item [$];
    int            exp_cnt  [$];
    bit            exp_left [$];

    // next expected group and finish pulses seen
    int gp = 0;
    int fin_total = 0;
    bit reset_seen = 1'b0;
    int mismatch_errs = 0;
    int run_errs = 0;
    int prop_errs = 0;

    vp_encoder vp_encoder_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got == exp) else begin
            mismatch_errs++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // valid entries below the length, in order, chunked by three
    task automatic build_expected(input int len);
        vp_pkg::item_t picked [$];
        vp_pkg::item_t it;
        vp_pkg::item_t blank;
        int            rest;
        blank = '0;
        for (int i = 0; i < `VP_W_LEN; i++) begin
            if (i < len && tbl_valid[i]) begin
                it.addr    = tbl_addr[i];
                it.w_data  = tbl_w[i];
                it.ia_data = tbl_ia[int'(tbl_pos[i])];
                picked.push_back(it);
            end
        end
        for (int g = 0; g < (picked.size() + DEPTH - 1) / DEPTH; g++) begin
            rest = picked.size() - g * DEPTH;
            // every run starts on the right bank
            exp_left.push_back((g % 2) == 1);
            exp_cnt.push_back((rest > DEPTH) ? DEPTH : rest);
            for (int s = 0; s < DEPTH; s++) begin
                exp_item.push_back((s < rest) ? picked[g * DEPTH + s] : blank);
            end
        end
    endtask

    task automatic fill_table(input int mode);
        for (int i = 0; i < `VP_W_LEN; i++) begin
            tbl_addr[i] = vp_pkg::addr_t'($urandom);
            tbl_pos[i]  = vp_pkg::pos_t'($urandom % `VP_IA_CHANNEL);
            tbl_w[i]    = vp_pkg::data_t'($urandom);
            case (mode)
                FILL_DENSE:  tbl_valid[i] = 1'b1;
                FILL_SPARSE: tbl_valid[i] = ($urandom % 3) == 0;
                default:     tbl_valid[i] = 1'b0;
            endcase
            // empty windows at the front and middle
            if (mode == FILL_SPARSE && (i < 3 || (i >= 12 && i < 18))) begin
                tbl_valid[i] = 1'b0;
            end
            // valid entries past the sparse length must stay out
            if (mode == FILL_SPARSE && i >= 28) begin
                tbl_valid[i] = 1'b1;
            end
        end
        for (int c = 0; c < `VP_IA_CHANNEL; c++) begin
            tbl_ia[c] = vp_pkg::data_t'($urandom);
        end
    endtask

    task automatic load_table(input int len);
        @(posedge i_clk);
        i_w_len <= vp_pkg::idx_t'(len);
        for (int i = 0; i < `VP_W_LEN; i++) begin
            i_addr_buf[i]  <= tbl_addr[i];
            i_valid_buf[i] <= tbl_valid[i];
            i_pos_buf[i]   <= tbl_pos[i];
            i_w_data[i]    <= tbl_w[i];
        end
        for (int c = 0; c < `VP_IA_CHANNEL; c++) begin
            i_ia_data[c] <= tbl_ia[c];
        end
    endtask

    task automatic run_case(input string label, input int mode, input int len,
                            input bit restart);
        int fin_base;
        int cycles;
        fill_table(mode);
        build_expected(len);
        load_table(len);
        fin_base = fin_total;
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        if (restart) begin
            // lands while the scan is still busy
            repeat (3) @(posedge i_clk);
            i_start <= 1'b1;
            @(posedge i_clk);
            i_start <= 1'b0;
        end
        cycles = 0;
        while (fin_total == fin_base && cycles < FIN_TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
        end
        if (fin_total == fin_base) begin
            run_errs++;
            $display("%s: no finish pulse within %0d cycles", label, FIN_TIMEOUT);
        end
        // room for a stray pulse
        repeat (6) @(posedge i_clk);
        if (fin_total - fin_base > 1) begin
            run_errs++;
            $display("%s: %0d finish pulses for one run", label, fin_total - fin_base);
        end
        if (gp != exp_cnt.size()) begin
            run_errs++;
            $display("%s: %0d banks announced in total, %0d expected", label, gp,
                     exp_cnt.size());
        end
    endtask

    // bank contents are compared on every ready pulse
    always @(posedge i_clk) begin : bank_check
        vp_pkg::addr_t a;
        vp_pkg::data_t w;
        vp_pkg::data_t ia;
        string         side;
        if (i_rst_n && !reset_seen) begin
            compare_value("o_right_ready", 32'(o_right_ready), 32'd0);
            compare_value("o_left_ready", 32'(o_left_ready), 32'd0);
            compare_value("o_finish", 32'(o_finish), 32'd0);
            for (int s = 0; s < DEPTH; s++) begin
                compare_value($sformatf("o_addr_right_buffer[%0d]", s),
                              32'(o_addr_right_buffer[s]), 0);
                compare_value($sformatf("o_w_data_right_buffer[%0d]", s),
                              32'(o_w_data_right_buffer[s]), 0);
                compare_value($sformatf("o_ia_data_right_buffer[%0d]", s),
                              32'(o_ia_data_right_buffer[s]), 0);
                compare_value($sformatf("o_addr_left_buffer[%0d]", s),
                              32'(o_addr_left_buffer[s]), 0);
                compare_value($sformatf("o_w_data_left_buffer[%0d]", s),
                              32'(o_w_data_left_buffer[s]), 0);
                compare_value($sformatf("o_ia_data_left_buffer[%0d]", s),
                              32'(o_ia_data_left_buffer[s]), 0);
            end
        end
        if (i_rst_n && (o_right_ready || o_left_ready) && gp < exp_cnt.size()) begin
            side = o_left_ready ? "left" : "right";
            compare_value("o_left_ready", 32'(o_left_ready), 32'(exp_left[gp]));
            for (int s = 0; s < DEPTH; s++) begin
                a  = o_left_ready ? o_addr_left_buffer[s] : o_addr_right_buffer[s];
                w  = o_left_ready ? o_w_data_left_buffer[s] : o_w_data_right_buffer[s];
                ia = o_left_ready ? o_ia_data_left_buffer[s] : o_ia_data_right_buffer[s];
                // unfilled slots keep their old address
                if (s < exp_cnt[gp]) begin
                    compare_value($sformatf("o_addr_%s_buffer[%0d]", side, s), 32'(a),
                                  32'(exp_item[gp * DEPTH + s].addr));
                end
                compare_value($sformatf("o_w_data_%s_buffer[%0d]", side, s), 32'(w),
                              32'(exp_item[gp * DEPTH + s].w_data));
                compare_value($sformatf("o_ia_data_%s_buffer[%0d]", side, s), 32'(ia),
                              32'(exp_item[gp * DEPTH + s].ia_data));
            end
            // partial bank goes out with the finish pulse
            if (exp_cnt[gp] < DEPTH) begin
                compare_value("o_finish", 32'(o_finish), 32'd1);
            end
        end
        if (i_rst_n && (o_right_ready || o_left_ready)) begin
            gp <= gp + 1;
        end
        if (i_rst_n && o_finish) begin
            fin_total <= fin_total + 1;
        end
        reset_seen <= reset_seen || i_rst_n;
    end

    a_one_bank: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_right_ready && o_left_ready))
        else begin
            prop_errs++;
            $display("both bank ready outputs high at %0t", $time);
        end

    // finish and ready are single cycle pulses
    a_finish_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_finish |=> !o_finish)
        else begin
            prop_errs++;
            $display("finish held high for more than one cycle at %0t", $time);
        end

    a_ready_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_right_ready || o_left_ready) |=> !(o_right_ready || o_left_ready))
        else begin
            prop_errs++;
            $display("bank ready held high for more than one cycle at %0t", $time);
        end

    initial begin
        void'($urandom(32'h0c27da28));
        i_rst_n <= 1'b0;
        i_start <= 1'b0;
        i_w_len <= '0;
        for (int i = 0; i < `VP_W_LEN; i++) begin
            i_addr_buf[i]  <= '0;
            i_valid_buf[i] <= 1'b0;
            i_pos_buf[i]   <= '0;
            i_w_data[i]    <= '0;
        end
        for (int c = 0; c < `VP_IA_CHANNEL; c++) begin
            i_ia_data[c] <= '0;
        end
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (3) @(posedge i_clk);
        run_case("dense", FILL_DENSE, 30, 1'b0);
        run_case("sparse", FILL_SPARSE, 28, 1'b0);
        run_case("tail of one", FILL_DENSE, 31, 1'b0);
        run_case("tail of two", FILL_DENSE, 5, 1'b0);
        run_case("empty", FILL_EMPTY, 32, 1'b0);
        run_case("start while busy", FILL_DENSE, 30, 1'b1);
        $display("errors: %0d mismatch, %0d run, %0d property",
                 mismatch_errs, run_errs, prop_errs);
        if (mismatch_errs == 0 && run_errs == 0 && prop_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+common
common/vp_pkg.sv
common/vp_item_if.sv
rtl/vp_scan_ctrl.sv
rtl/vp_operand_gather.sv
rtl/vp_bank_pair.sv
rtl/vp_encoder.sv
bench/tb_vp_encoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run for the sparse encoder testbench

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_vp_encoder \
    -Mdir obj_dir -o sim_vp_encoder > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $build_log"
    exit 1
fi

./obj_dir/sim_vp_encoder > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $sim_log"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$sim_log"; then
    echo "testbench reported failure, see $sim_log"
    exit 1
fi

echo "testbench run clean, see $sim_log"
exit 0
